//--- files.f
pipe_pkg.sv
stage_bus.sv
pipe_stage_reg.sv
instr_decode.sv
hazard_unit.sv
forward_unit.sv
pipe_ctrl_top.sv
tb_pipe_ctrl.sv

//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - pipe_pkg.sv
  - stage_bus.sv
  - pipe_stage_reg.sv
  - instr_decode.sv
  - hazard_unit.sv
  - forward_unit.sv
  - pipe_ctrl_top.sv
  - target: test
    files:
      - tb_pipe_ctrl.sv

//--- pipe_vectors.txt
# I <pc> <instr> <redirect when in EX>   issue lines, in fetch order
# R <pc> <instr> <rd>                    expected retire lines, in program order
I 1000 00500093 0
I 1004 00700113 0
I 1008 123451b7 0
I 100c 00000013 0
I 1010 00208233 0
I 1014 004202b3 0
I 1018 00020333 0
I 101c 00100393 0
I 1020 00238393 0
I 1024 00738433 0
I 1028 0000b483 0
I 102c 00248533 0
I 1030 00a4b423 0
I 1034 01013583 0
I 1038 00b08633 0
I 103c 00208863 1
# wrong path behind the branch, must never retire
I 1040 00100693 0
I 1044 00200713 0
I 104c 00e687b3 0
I 1050 00378813 0
R 1000 00500093 01
R 1004 00700113 02
R 1008 123451b7 03
R 100c 00000013 00
R 1010 00208233 04
R 1014 004202b3 05
R 1018 00020333 06
R 101c 00100393 07
R 1020 00238393 07
R 1024 00738433 08
R 1028 0000b483 09
R 102c 00248533 0a
R 1030 00a4b423 00
R 1034 01013583 0b
R 1038 00b08633 0c
R 103c 00208863 00
R 104c 00e687b3 0f
R 1050 00378813 10

//--- tb_pipe_ctrl.sv
// reads pipe_vectors.txt from the project root; the fetch presented during a redirect is dropped
`timescale 1ns/1ns

module tb_pipe_ctrl;
    import pipe_pkg::*;

    localparam int PC_W  = 64;
    localparam int MAX_V = 64;

    logic            clk;
    logic            rst_n_i;
    logic            fetch_valid_i;
    logic [PC_W-1:0] fetch_pc_i;
    instr_t          fetch_instr_i;
    logic            redirect_i;
    logic            stall_o;
    logic            ex_valid_o;
    logic [PC_W-1:0] ex_pc_o;
    instr_t          ex_instr_o;
    fwd_sel_e        fwd_a_o;
    fwd_sel_e        fwd_b_o;
    logic            retire_valid_o;
    logic [PC_W-1:0] retire_pc_o;
    instr_t          retire_instr_o;
    reg_addr_t       retire_rd_o;

    logic [PC_W-1:0] iss_pc [MAX_V];
    instr_t          iss_instr [MAX_V];
    logic            iss_redir [MAX_V];
    logic [PC_W-1:0] ret_pc [MAX_V];
    instr_t          ret_instr [MAX_V];
    reg_addr_t       ret_rd [MAX_V];
    int              n_iss;
    int              n_ret;
    int              ret_seen;
    int              nxt;
    int              gap;
    int              nogap;
    int              cycles;
    int              limit;
    // model stages hold issue indices and -1 marks a bubble
    int              id_s;
    int              ex_s;
    int              mem_s;
    int              wb_s;
    logic            running;
    logic            advance;
    logic            redir_next;
    logic            stall_p;
    integer          seed;

    pipe_ctrl_top #(.PC_W(PC_W)) i_pipe_ctrl_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_pc_i     (fetch_pc_i),
        .fetch_instr_i  (fetch_instr_i),
        .redirect_i     (redirect_i),
        .stall_o        (stall_o),
        .ex_valid_o     (ex_valid_o),
        .ex_pc_o        (ex_pc_o),
        .ex_instr_o     (ex_instr_o),
        .fwd_a_o        (fwd_a_o),
        .fwd_b_o        (fwd_b_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_instr_o (retire_instr_o),
        .retire_rd_o    (retire_rd_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("FAILED %s expected %h got %h", name, exp, got);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_stall(input logic exp, input logic got);
        if (got !== exp) begin
            report_mismatch("stall_o", exp, got);
        end
    endtask

    task automatic check_fwd(input string name, input fwd_sel_e exp, input fwd_sel_e got);
        if (got !== exp) begin
            report_mismatch(name, exp, got);
        end
    endtask

    task automatic check_ex(input logic valid, input logic [PC_W-1:0] pc,
                            input instr_t ins);
        if (ex_valid_o !== valid) begin
            report_mismatch("ex_valid_o", valid, ex_valid_o);
        end else if (valid) begin
            if (ex_pc_o !== pc) begin
                report_mismatch("ex_pc_o", pc, ex_pc_o);
            end
            if (ex_instr_o !== ins) begin
                report_mismatch("ex_instr_o", ins, ex_instr_o);
            end
        end
    endtask

    task automatic check_retire(input logic [PC_W-1:0] pc, input instr_t ins,
                                input reg_addr_t rd);
        if (retire_valid_o !== 1'b1) begin
            report_mismatch("retire_valid_o", 1, retire_valid_o);
        end
        if (retire_pc_o !== pc) begin
            report_mismatch("retire_pc_o", pc, retire_pc_o);
        end
        if (retire_instr_o !== ins) begin
            report_mismatch("retire_instr_o", ins, retire_instr_o);
        end
        if (retire_rd_o !== rd) begin
            report_mismatch("retire_rd_o", rd, retire_rd_o);
        end
    endtask

    // destination by RV64I format or zero when nothing is written
    function automatic reg_addr_t dest_of(input instr_t ins);
        reg_addr_t rd;
        case (ins[6:0])
            OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32,
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR: rd = ins[11:7];
            default: rd = '0;
        endcase
        return rd;
    endfunction

    function automatic logic reads_src(input instr_t ins, input logic second);
        opcode_t op;
        logic    used;
        op = ins[6:0];
        if (second) begin
            used = (op == OPC_OP) || (op == OPC_OP_32) || (op == OPC_STORE) || (op == OPC_BRANCH);
        end else begin
            used = !((op == OPC_LUI) || (op == OPC_AUIPC) || (op == OPC_JAL));
        end
        return used;
    endfunction

    function automatic logic expect_stall();
        instr_t    ld;
        instr_t    user;
        reg_addr_t dst;
        logic      hit;
        hit = 1'b0;
        if (ex_s >= 0 && id_s >= 0) begin
            ld   = iss_instr[ex_s];
            user = iss_instr[id_s];
            dst  = dest_of(ld);
            if (ld[6:0] == OPC_LOAD && dst != '0) begin
                hit = (reads_src(user, 1'b0) && user[19:15] == dst) ||
                      (reads_src(user, 1'b1) && user[24:20] == dst);
            end
        end
        return hit;
    endfunction

    // youngest matching producer wins with MEM before WB
    function automatic fwd_sel_e expect_fwd(input logic second);
        reg_addr_t src;
        fwd_sel_e  sel;
        sel = FWD_REG;
        if (ex_s >= 0) begin
            src = second ? iss_instr[ex_s][24:20] : iss_instr[ex_s][19:15];
            if (reads_src(iss_instr[ex_s], second) && src != '0) begin
                if (mem_s >= 0 && dest_of(iss_instr[mem_s]) == src) begin
                    sel = FWD_MEM;
                end else if (wb_s >= 0 && dest_of(iss_instr[wb_s]) == src) begin
                    sel = FWD_WB;
                end
            end
        end
        return sel;
    endfunction

    task automatic load_vectors();
        integer           fd;
        integer           cnt;
        logic [63:0]      tag;
        logic [8*160-1:0] rest;
        logic [PC_W-1:0]  pc;
        instr_t           ins;
        logic [7:0]       extra;
        fd = $fopen("pipe_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("could not open pipe_vectors.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "I") begin
                    cnt = $fscanf(fd, "%h %h %h", pc, ins, extra);
                    if (cnt != 3) begin
                        abort_run("malformed issue line in pipe_vectors.txt");
                    end else begin
                        iss_pc[n_iss]    = pc;
                        iss_instr[n_iss] = ins;
                        iss_redir[n_iss] = extra[0];
                        n_iss++;
                    end
                end else if (tag == "R") begin
                    cnt = $fscanf(fd, "%h %h %h", pc, ins, extra);
                    if (cnt != 3) begin
                        abort_run("malformed retire line in pipe_vectors.txt");
                    end else begin
                        ret_pc[n_ret]    = pc;
                        ret_instr[n_ret] = ins;
                        ret_rd[n_ret]    = extra[4:0];
                        n_ret++;
                    end
                end else begin
                    cnt = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // the two fetches behind a redirecting instruction go back to back
    always @(posedge clk) begin
        if (running) begin
            if (advance) begin
                if (nogap > 0) begin
                    nogap = nogap - 1;
                end
                if (iss_redir[nxt]) begin
                    nogap = 2;
                end
                nxt = nxt + 1;
                gap = (nogap == 0 && ($random(seed) & 7) == 0) ? 1 : 0;
            end
            if (gap > 0) begin
                gap = gap - 1;
                fetch_valid_i <= 1'b0;
            end else begin
                fetch_valid_i <= (nxt < n_iss);
            end
            if (nxt < n_iss) begin
                fetch_pc_i    <= iss_pc[nxt];
                fetch_instr_i <= iss_instr[nxt];
            end
            redirect_i <= redir_next;
        end
    end

    // checks at the falling edge before the model steps to the next rising edge
    always @(negedge clk) begin
        if (running) begin
            stall_p = expect_stall();
            check_stall(stall_p, stall_o);
            check_fwd("fwd_a_o", expect_fwd(1'b0), fwd_a_o);
            check_fwd("fwd_b_o", expect_fwd(1'b1), fwd_b_o);
            if (ex_s >= 0) begin
                check_ex(1'b1, iss_pc[ex_s], iss_instr[ex_s]);
            end else begin
                check_ex(1'b0, '0, '0);
            end
            if (wb_s >= 0) begin
                if (ret_seen >= n_ret) begin
                    abort_run("an instruction retired beyond the expected list");
                end else begin
                    check_retire(ret_pc[ret_seen], ret_instr[ret_seen], ret_rd[ret_seen]);
                    ret_seen++;
                end
            end else if (retire_valid_o !== 1'b0) begin
                report_mismatch("retire_valid_o", 0, retire_valid_o);
            end
            advance = fetch_valid_i && (redirect_i || !stall_p);
            wb_s    = mem_s;
            mem_s   = ex_s;
            ex_s    = (redirect_i || stall_p) ? -1 : id_s;
            if (redirect_i) begin
                id_s = -1;
            end else if (!stall_p) begin
                id_s = fetch_valid_i ? nxt : -1;
            end
            redir_next = (ex_s >= 0) && iss_redir[ex_s];
            cycles++;
            if (cycles >= limit) begin
                abort_run($sformatf("retirement stalled after %0d cycles", cycles));
            end
        end
    end

    initial begin
        seed          = 32'h90f2_a308;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_instr_i = '0;
        redirect_i    = 1'b0;
        running       = 1'b0;
        advance       = 1'b0;
        redir_next    = 1'b0;
        id_s          = -1;
        ex_s          = -1;
        mem_s         = -1;
        wb_s          = -1;
        load_vectors();
        limit = 4 * (n_iss + n_ret) + 50;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        running <= 1'b1;
        wait (ret_seen == n_ret);
        // a few more edges to catch a stray retire
        repeat (3) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

//--- pipe_ctrl_top.sv
// fetch must hold pc and instr while stall_o is high; no datapath, register file or memory
`timescale 1ns/1ns

module pipe_ctrl_top #(
    parameter int PC_W = 64
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                fetch_valid_i,
    input  logic [PC_W-1:0]     fetch_pc_i,
    input  pipe_pkg::instr_t    fetch_instr_i,
    input  logic                redirect_i,
    output logic                stall_o,
    output logic                ex_valid_o,
    output logic [PC_W-1:0]     ex_pc_o,
    output pipe_pkg::instr_t    ex_instr_o,
    output pipe_pkg::fwd_sel_e  fwd_a_o,
    output pipe_pkg::fwd_sel_e  fwd_b_o,
    output logic                retire_valid_o,
    output logic [PC_W-1:0]     retire_pc_o,
    output pipe_pkg::instr_t    retire_instr_o,
    output pipe_pkg::reg_addr_t retire_rd_o
);
    logic id_enable;
    logic id_flush;
    logic ex_flush;
    logic fetch_take;

    stage_bus #(.PC_W(PC_W)) fetch_bus ();
    stage_bus #(.PC_W(PC_W)) id_bus ();
    stage_bus #(.PC_W(PC_W)) dec_bus ();
    stage_bus #(.PC_W(PC_W)) ex_bus ();
    stage_bus #(.PC_W(PC_W)) mem_bus ();
    stage_bus #(.PC_W(PC_W)) wb_bus ();

    // undecoded on the fetch side, decode runs in ID
    assign fetch_bus.valid    = fetch_take;
    assign fetch_bus.pc       = fetch_pc_i;
    assign fetch_bus.instr    = fetch_instr_i;
    assign fetch_bus.rd       = '0;
    assign fetch_bus.rs1      = '0;
    assign fetch_bus.rs2      = '0;
    assign fetch_bus.wen      = 1'b0;
    assign fetch_bus.uses_rs1 = 1'b0;
    assign fetch_bus.uses_rs2 = 1'b0;
    assign fetch_bus.is_load  = 1'b0;

    pipe_stage_reg #(.PC_W(PC_W)) id_reg (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (id_flush),
        .enable_i (id_enable),
        .in_bus   (fetch_bus),
        .out_bus  (id_bus)
    );

    instr_decode i_instr_decode (
        .in_bus  (id_bus),
        .out_bus (dec_bus)
    );

    hazard_unit i_hazard_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .id_bus        (dec_bus),
        .ex_bus        (ex_bus),
        .redirect_i    (redirect_i),
        .fetch_valid_i (fetch_valid_i),
        .stall_o       (stall_o),
        .id_enable_o   (id_enable),
        .id_flush_o    (id_flush),
        .ex_flush_o    (ex_flush),
        .fetch_take_o  (fetch_take)
    );

    pipe_stage_reg #(.PC_W(PC_W)) ex_reg (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (ex_flush),
        .enable_i (1'b1),
        .in_bus   (dec_bus),
        .out_bus  (ex_bus)
    );

    // back end never stalls or flushes
    pipe_stage_reg #(.PC_W(PC_W)) mem_reg (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (1'b0),
        .enable_i (1'b1),
        .in_bus   (ex_bus),
        .out_bus  (mem_bus)
    );

    pipe_stage_reg #(.PC_W(PC_W)) wb_reg (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .flush_i  (1'b0),
        .enable_i (1'b1),
        .in_bus   (mem_bus),
        .out_bus  (wb_bus)
    );

    forward_unit i_forward_unit (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ex_bus  (ex_bus),
        .mem_bus (mem_bus),
        .wb_bus  (wb_bus),
        .fwd_a_o (fwd_a_o),
        .fwd_b_o (fwd_b_o)
    );

    assign ex_valid_o = ex_bus.valid;
    assign ex_pc_o    = ex_bus.pc;
    assign ex_instr_o = ex_bus.instr;

    // retire record straight from WB
    assign retire_valid_o = wb_bus.valid;
    assign retire_pc_o    = wb_bus.pc;
    assign retire_instr_o = wb_bus.instr;
    assign retire_rd_o    = wb_bus.rd;

endmodule

//--- forward_unit.sv
// selects only for a valid EX instruction; clk and rst_n_i serve the assertion alone
`timescale 1ns/1ns

module forward_unit (
    input  logic               clk,
    input  logic               rst_n_i,
    stage_bus.snk              ex_bus,
    stage_bus.snk              mem_bus,
    stage_bus.snk              wb_bus,
    output pipe_pkg::fwd_sel_e fwd_a_o,
    output pipe_pkg::fwd_sel_e fwd_b_o
);
    import pipe_pkg::*;

    logic mem_fwd_ok;
    logic wb_fwd_ok;

    // youngest producer wins
    function automatic fwd_sel_e pick_source(
        input logic      used,
        input reg_addr_t src,
        input logic      mem_ok,
        input reg_addr_t mem_rd,
        input logic      wb_ok,
        input reg_addr_t wb_rd
    );
        fwd_sel_e sel;
        sel = FWD_REG;
        if (used && (src != '0)) begin
            if (mem_ok && (mem_rd == src)) begin
                sel = FWD_MEM;
            end else if (wb_ok && (wb_rd == src)) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    assign mem_fwd_ok = mem_bus.valid && mem_bus.wen;
    assign wb_fwd_ok  = wb_bus.valid && wb_bus.wen;

    assign fwd_a_o = pick_source(ex_bus.valid && ex_bus.uses_rs1, ex_bus.rs1,
                                 mem_fwd_ok, mem_bus.rd, wb_fwd_ok, wb_bus.rd);
    assign fwd_b_o = pick_source(ex_bus.valid && ex_bus.uses_rs2, ex_bus.rs2,
                                 mem_fwd_ok, mem_bus.rd, wb_fwd_ok, wb_bus.rd);

    // load data is not ready in MEM; the load-use stall must have covered this
    a_no_mem_load_fwd: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ((fwd_a_o == FWD_MEM) || (fwd_b_o == FWD_MEM)) |-> !mem_bus.is_load
    ) else $error("forwarding from a load still in MEM");

endmodule

//--- hazard_unit.sv
// combinational control; clk and rst_n_i feed only the stall check, and redirect targets EX
`timescale 1ns/1ns

module hazard_unit (
    input  logic  clk,
    input  logic  rst_n_i,
    stage_bus.snk id_bus,
    stage_bus.snk ex_bus,
    input  logic  redirect_i,
    input  logic  fetch_valid_i,
    output logic  stall_o,
    output logic  id_enable_o,
    output logic  id_flush_o,
    output logic  ex_flush_o,
    output logic  fetch_take_o
);
    logic ex_load_dest;
    logic rs1_hit;
    logic rs2_hit;

    // a load writing x0 never blocks anyone
    assign ex_load_dest = ex_bus.valid && ex_bus.is_load && (ex_bus.rd != '0);

    assign rs1_hit = id_bus.uses_rs1 && (id_bus.rs1 == ex_bus.rd);
    assign rs2_hit = id_bus.uses_rs2 && (id_bus.rs2 == ex_bus.rd);

    assign stall_o = ex_load_dest && id_bus.valid && (rs1_hit || rs2_hit);

    // fetch is consumed only when ID is free and not being squashed
    assign fetch_take_o = fetch_valid_i && !stall_o && !redirect_i;

    // ID holds its instruction for the stall cycle
    assign id_enable_o = !stall_o;

    // idle fetch leaves an empty ID slot; a stalled ID keeps its own
    assign id_flush_o = redirect_i || (!fetch_take_o && !stall_o);

    // stall drops a bubble into EX, redirect kills the EX occupant's successors
    assign ex_flush_o = redirect_i || stall_o;

    // the bubble behind a stall clears the load from EX, so the stall must end
    a_stall_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        stall_o |=> !stall_o
    ) else $error("load-use stall held for a second cycle");

endmodule

//--- instr_decode.sv
// combinational RV64I classifier; rd reads as zero for formats that write no register
`timescale 1ns/1ns

module instr_decode (
    stage_bus.snk in_bus,
    stage_bus.src out_bus
);
    import pipe_pkg::*;

    opcode_t   opcode;
    reg_addr_t rd_field;
    logic      writes_rd;
    logic      src1_used;
    logic      src2_used;

    assign opcode   = in_bus.instr[6:0];
    assign rd_field = in_bus.instr[11:7];

    always_comb begin
        writes_rd = 1'b0;
        src1_used = 1'b0;
        src2_used = 1'b0;
        case (opcode)
            OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_JALR: begin
                writes_rd = 1'b1;
                src1_used = 1'b1;
            end
            OPC_OP, OPC_OP_32: begin
                writes_rd = 1'b1;
                src1_used = 1'b1;
                src2_used = 1'b1;
            end
            // U and J formats, no register sources
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                writes_rd = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                src1_used = 1'b1;
                src2_used = 1'b1;
            end
            // csr ops read rs1, no tracked write
            OPC_SYSTEM: begin
                src1_used = 1'b1;
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

    // instruction identity unchanged
    assign out_bus.valid = in_bus.valid;
    assign out_bus.pc    = in_bus.pc;
    assign out_bus.instr = in_bus.instr;

    // store and branch reuse bits 11:7 as immediate
    assign out_bus.rd  = writes_rd ? rd_field : '0;
    assign out_bus.rs1 = in_bus.instr[19:15];
    assign out_bus.rs2 = in_bus.instr[24:20];

    // writes to x0 are dropped here
    assign out_bus.wen      = writes_rd && (rd_field != '0);
    assign out_bus.uses_rs1 = src1_used;
    assign out_bus.uses_rs2 = src2_used;
    assign out_bus.is_load  = (opcode == OPC_LOAD);

endmodule

//--- pipe_stage_reg.sv
// one-cycle stage register; flush beats enable, and data fields are left stale when flushed
`timescale 1ns/1ns

module pipe_stage_reg #(
    parameter int PC_W = 64
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  flush_i,
    input  logic  enable_i,
    stage_bus.snk in_bus,
    stage_bus.src out_bus
);
    import pipe_pkg::*;

    logic            valid_q;
    logic [PC_W-1:0] pc_q;
    instr_t          instr_q;
    reg_addr_t       rd_q;
    reg_addr_t       rs1_q;
    reg_addr_t       rs2_q;
    logic            wen_q;
    logic            uses_rs1_q;
    logic            uses_rs2_q;
    logic            is_load_q;

    // valid holds while the stage is stalled
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (enable_i) begin
            valid_q <= in_bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable_i) begin
            pc_q       <= in_bus.pc;
            instr_q    <= in_bus.instr;
            rd_q       <= in_bus.rd;
            rs1_q      <= in_bus.rs1;
            rs2_q      <= in_bus.rs2;
            wen_q      <= in_bus.wen;
            uses_rs1_q <= in_bus.uses_rs1;
            uses_rs2_q <= in_bus.uses_rs2;
            is_load_q  <= in_bus.is_load;
        end
    end

    assign out_bus.valid    = valid_q;
    assign out_bus.pc       = pc_q;
    assign out_bus.instr    = instr_q;
    assign out_bus.rd       = rd_q;
    assign out_bus.rs1      = rs1_q;
    assign out_bus.rs2      = rs2_q;
    assign out_bus.wen      = wen_q;
    assign out_bus.uses_rs1 = uses_rs1_q;
    assign out_bus.uses_rs2 = uses_rs2_q;
    assign out_bus.is_load  = is_load_q;

    // decode squashes x0 writes, so none may travel down the pipe
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        out_bus.valid |-> !(out_bus.wen && (out_bus.rd == '0))
    ) else $error("stage register carries a write enable for x0");

endmodule

//--- stage_bus.sv
// plain bundle with no clock; every field except valid is meaningful only while valid is high
`timescale 1ns/1ns

interface stage_bus #(
    parameter int PC_W = 64
);
    import pipe_pkg::*;

    logic            valid;
    logic [PC_W-1:0] pc;
    instr_t          instr;
    reg_addr_t       rd;
    reg_addr_t       rs1;
    reg_addr_t       rs2;
    logic            wen;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            is_load;

    // driven by a stage register or the decoder
    modport src (
        output valid, pc, instr,
        output rd, rs1, rs2,
        output wen, uses_rs1, uses_rs2, is_load
    );

    // read by the next register or a control unit
    modport snk (
        input valid, pc, instr,
        input rd, rs1, rs2,
        input wen, uses_rs1, uses_rs2, is_load
    );

endinterface

//--- pipe_pkg.sv
// RV64I base opcodes only; compressed and extension opcodes are not recognised
package pipe_pkg;

    // raw 32-bit instruction word as fetched
    typedef logic [31:0] instr_t;

    // architectural register index, x0..x31
    typedef logic [4:0] reg_addr_t;

    // major opcode field, instr[6:0]
    typedef logic [6:0] opcode_t;

    // RV64I major opcodes
    localparam opcode_t OPC_LOAD      = 7'b0000011;
    localparam opcode_t OPC_STORE     = 7'b0100011;
    localparam opcode_t OPC_BRANCH    = 7'b1100011;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_OP_32     = 7'b0111011;
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_JAL       = 7'b1101111;
    localparam opcode_t OPC_JALR      = 7'b1100111;
    localparam opcode_t OPC_SYSTEM    = 7'b1110011;

    // EX operand source select
    // FWD_REG: register file read
    // FWD_MEM: result of the instruction in MEM
    // FWD_WB: result of the instruction in WB
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

endpackage
